/* Bender.yml */
package:
  name: cas_input

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cas_pkg.sv
      - verilog/adc_capture.sv
      - verilog/dc_tracker.sv
      - verilog/tape_slicer.sv
      - verilog/cas_audio_mixer.sv
      - verilog/cas_input_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_cas_input.sv

/* bench/tb_cas_input.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cas_cfg.svh"

// testbench for the cassette input path
// random walk ADC data, random sync gaps, random side inputs
module tb_cas_input
	import cas_pkg::*;
();

	localparam int SEED             = 69;
	localparam int NUM_SAMPLES      = 1600;
	// source select stays on the ADC for this many samples first
	localparam int ADC_ONLY_SAMPLES = 1100;
	localparam int STB_TIMEOUT      = 16;
	localparam int MAX_CYCLES       = 40000;
	localparam int DEPTH            = 1 << `CAS_AVG_LOG2;
	localparam int ADC_MAX          = (1 << `CAS_ADC_W) - 1;

	logic        clk_sys;
	logic        i_rst;
	logic        i_adc_sync;
	adc_sample_t i_adc_data;
	logic        i_file_bit;
	logic        i_src_adc;
	logic        i_monitor;
	logic        i_sndout;
	sound_t      i_sound;
	logic        o_sample_stb;
	adc_sample_t o_sample;
	adc_sample_t o_dc_level;
	logic        o_cas_bit;
	audio_word_t o_audio;

	int   errors;
	int   toggles;
	int   strobes;
	int   bit_flips;
	int   seed_val;
	int   walk;
	int   walk_dir;
	logic timed_out;
	logic check_en;

	// reference model state with one set per pipeline stage
	logic        m_sync_q;
	logic        m_cap_stb;
	adc_sample_t m_cap_sample;
	logic        m_trk_stb;
	adc_sample_t m_trk_sample;
	adc_sample_t m_level;
	logic        m_adc_bit;
	logic        m_cas_bit;
	audio_word_t m_audio;
	int          m_total;
	int          m_hist[$];

	cas_input_top i_cas_input_top (
		.clk_sys      (clk_sys),
		.i_rst        (i_rst),
		.i_adc_sync   (i_adc_sync),
		.i_adc_data   (i_adc_data),
		.i_file_bit   (i_file_bit),
		.i_src_adc    (i_src_adc),
		.i_monitor    (i_monitor),
		.i_sndout     (i_sndout),
		.i_sound      (i_sound),
		.o_sample_stb (o_sample_stb),
		.o_sample     (o_sample),
		.o_dc_level   (o_dc_level),
		.o_cas_bit    (o_cas_bit),
		.o_audio      (o_audio)
	);

	// 8 ns period
	initial
	begin
		clk_sys = 1'b0;
	end

	always #4 clk_sys = ~clk_sys;

	task automatic flag_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// inputs change 1 ns after the edge, so they are stable here
	// later stages are updated first so each sees the value before the edge
	always @(posedge clk_sys)
	begin : ref_model
		logic        tape;
		audio_word_t word;
		int          s;
		int          l;
		if (i_rst)
		begin
			m_sync_q  = i_adc_sync;
			m_cap_stb = 1'b0;
			m_trk_stb = 1'b0;
			m_level   = '0;
			m_adc_bit = 1'b0;
			m_cas_bit = 1'b0;
			m_audio   = '0;
			m_total   = 0;
			m_hist.delete();
		end
		else
		begin
			// source select and audio word take 1 cycle
			tape = i_src_adc ? m_adc_bit : i_file_bit;
			m_cas_bit = tape;
			word = {i_sndout, i_sound, 3'b000};
			// monitored tape flips sound bit 5, which lands on bit 8
			if (i_monitor && tape)
			begin
				word[8] = ~word[8];
			end
			m_audio = word;
			// hysteresis on the sample aligned with its mean
			if (m_trk_stb)
			begin
				s = int'(m_trk_sample);
				l = int'(m_level);
				if (s + `CAS_THRESHOLD < l)
				begin
					if (!m_adc_bit)
						bit_flips++;
					m_adc_bit = 1'b1;
				end
				else if (s > l + `CAS_THRESHOLD)
				begin
					if (m_adc_bit)
						bit_flips++;
					m_adc_bit = 1'b0;
				end
			end
			// mean over the last DEPTH samples where missing ones count as zero
			m_trk_stb = m_cap_stb;
			if (m_cap_stb)
			begin
				m_hist.push_back(int'(m_cap_sample));
				m_total += int'(m_cap_sample);
				if (m_hist.size() > DEPTH)
					m_total -= m_hist.pop_front();
				m_level      = adc_sample_t'(m_total >> `CAS_AVG_LOG2);
				m_trk_sample = m_cap_sample;
			end
			// toggle of the sync line takes the sample
			m_cap_stb = (i_adc_sync !== m_sync_q);
			if (m_cap_stb)
				m_cap_sample = i_adc_data;
			m_sync_q = i_adc_sync;
		end
	end

	// outputs compared mid cycle away from the edges
	always @(negedge clk_sys)
	begin
		if (!i_rst && check_en)
		begin
			if (o_sample_stb === 1'b1)
				strobes++;
			if (o_sample_stb !== m_cap_stb)
				flag_mismatch("o_sample_stb", o_sample_stb, m_cap_stb);
			if (m_cap_stb && (o_sample !== m_cap_sample))
				flag_mismatch("o_sample", o_sample, m_cap_sample);
			if (o_dc_level !== m_level)
				flag_mismatch("o_dc_level", o_dc_level, m_level);
			if (o_cas_bit !== m_cas_bit)
				flag_mismatch("o_cas_bit", o_cas_bit, m_cas_bit);
			if (o_audio !== m_audio)
				flag_mismatch("o_audio", o_audio, m_audio);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic drive_side_inputs();
		i_sound    = sound_t'($urandom_range(0, (1 << `CAS_SOUND_W) - 1));
		i_sndout   = $urandom_range(0, 1);
		i_monitor  = $urandom_range(0, 1);
		i_file_bit = $urandom_range(0, 1);
	endtask

	// one clock with new side inputs just after the edge
	task automatic step_cycle();
		@(posedge clk_sys);
		#1;
		drive_side_inputs();
	endtask

	// slow walk with occasional turns that bounces off the ends of the ADC range
	task automatic advance_walk();
		int step;
		if ($urandom_range(0, 31) == 0)
			walk_dir = -walk_dir;
		step = 20 + $urandom_range(0, 59);
		walk = walk + walk_dir * step;
		if (walk > ADC_MAX)
		begin
			walk     = ADC_MAX;
			walk_dir = -1;
		end
		if (walk < 0)
		begin
			walk     = 0;
			walk_dir = 1;
		end
	endtask

	// called right after the sampling edge with the strobe due in the next cycle
	task automatic wait_for_strobe();
		int   waited;
		logic seen;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < STB_TIMEOUT)
		begin
			@(negedge clk_sys);
			waited++;
			if (o_sample_stb === 1'b1)
				seen = 1'b1;
		end
		if (!seen)
		begin
			errors++;
			timed_out = 1'b1;
			$display("no o_sample_stb within %0d cycles of the sync toggle, at %0t ns",
				STB_TIMEOUT, $time);
		end
		else if (waited != 1)
		begin
			errors++;
			$display("o_sample_stb came %0d cycles after the sampling edge instead of 1",
				waited);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin : main_seq
		int i;
		seed_val   = $urandom(SEED);
		i_rst      = 1'b1;
		// sync held high so the capture reference must come from the live level
		i_adc_sync = 1'b1;
		i_adc_data = '0;
		// side inputs busy through reset so only the reset can zero the outputs
		i_file_bit = 1'b1;
		i_src_adc  = 1'b0;
		i_monitor  = 1'b1;
		i_sndout   = 1'b1;
		i_sound    = '1;
		errors     = 0;
		toggles    = 0;
		strobes    = 0;
		bit_flips  = 0;
		timed_out  = 1'b0;
		check_en   = 1'b0;
		walk       = ADC_MAX / 2;
		walk_dir   = 1;
		repeat (5) @(posedge clk_sys);
		#1;
		i_rst      = 1'b0;
		i_file_bit = 1'b0;
		i_src_adc  = 1'b1;
		i_monitor  = 1'b0;
		i_sndout   = 1'b0;
		i_sound    = '0;
		check_en   = 1'b1;
		// nothing may move before the first toggle
		for (i = 0; i < 4; i++)
		begin
			@(negedge clk_sys);
			if (o_sample_stb !== 1'b0)
				flag_mismatch("o_sample_stb", o_sample_stb, 0);
			if (o_cas_bit !== 1'b0)
				flag_mismatch("o_cas_bit", o_cas_bit, 0);
			if (o_audio !== '0)
				flag_mismatch("o_audio", o_audio, 0);
		end
		for (i = 0; i < NUM_SAMPLES && !timed_out; i++)
		begin
			step_cycle();
			// later on the source select moves around as well
			if (i >= ADC_ONLY_SAMPLES && $urandom_range(0, 3) == 0)
				i_src_adc = ~i_src_adc;
			advance_walk();
			i_adc_sync = ~i_adc_sync;
			i_adc_data = adc_sample_t'(walk);
			toggles++;
			@(posedge clk_sys);
			wait_for_strobe();
			repeat ($urandom_range(0, 11)) step_cycle();
		end
		// let the last sample run through the pipeline
		repeat (8) step_cycle();
		if (strobes != toggles)
		begin
			errors++;
			$display("saw %0d strobes for %0d sync toggles", strobes, toggles);
		end
		if (bit_flips < 4)
		begin
			errors++;
			$display("the sliced tape bit changed only %0d times", bit_flips);
		end
		$display("tb_cas_input: %0d errors, %0d toggles, %0d strobes, %0d tape bit changes",
			errors, toggles, strobes, bit_flips);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// overall cycle limit on the whole run
	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("run went past %0d cycles without finishing, %0d errors so far",
			MAX_CYCLES, errors);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/cas_pkg.sv
verilog/adc_capture.sv
verilog/dc_tracker.sv
verilog/tape_slicer.sv
verilog/cas_audio_mixer.sv
verilog/cas_input_top.sv
bench/tb_cas_input.sv

/* verilog/adc_capture.sv */
`timescale 1ns/1ps
`default_nettype none

// the ADC flags each new conversion by toggling its sync line
// a toggle in either direction means one fresh sample
module adc_capture
	import cas_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        i_rst,
	input  wire logic        i_adc_sync,
	input  wire adc_sample_t i_adc_data,
	output logic             o_stb,
	output adc_sample_t      o_sample
);

	// last sync level seen on a clock edge
	logic sync_q;
	logic sync_edge;

	// either polarity of change counts
	assign sync_edge = sync_q ^ i_adc_sync;

	////////////////////////////////////////////////////////////////////
	// toggle detect
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (i_rst)
		begin
			// take the live level so reset release gives no false strobe
			sync_q <= i_adc_sync;
			o_stb  <= 1'b0;
		end
		else
		begin
			sync_q <= i_adc_sync;
			// single cycle pulse per toggle
			o_stb  <= sync_edge;
		end
	end

	// sample register, only loaded on a toggle
	always_ff @(posedge clk_sys)
	begin
		if (sync_edge)
		begin
			o_sample <= i_adc_data;
		end
	end

endmodule

`default_nettype wire

/* verilog/cas_audio_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

// tape source select and audio word assembly
// one selected bit feeds both the machine and the monitor path
module cas_audio_mixer
	import cas_pkg::*;
(
	input  wire logic   clk_sys,
	input  wire logic   i_rst,
	input  wire logic   i_adc_bit,
	input  wire logic   i_file_bit,
	input  wire logic   i_src_adc,
	input  wire logic   i_monitor,
	input  wire logic   i_sndout,
	input  wire sound_t i_sound,
	output logic        o_cas_bit,
	output audio_word_t o_audio
);

	logic        tape_bit;
	logic        mon_bit;
	audio_word_t audio_next;

	////////////////////////////////////////////////////////////////////
	// mix
	////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// ADC slicer or file player
		tape_bit = i_src_adc ? i_adc_bit : i_file_bit;
		// tape only heard while monitoring
		mon_bit  = i_monitor & tape_bit;
		// speaker bit loudest, then the DAC, tape bit quiet in sound bit 5
		audio_next = {
			i_sndout,
			i_sound[11:6],
			i_sound[5] ^ mon_bit,
			i_sound[4:0],
			{AUDIO_PAD_W{1'b0}}
		};
	end

	// both outputs registered every cycle
	always_ff @(posedge clk_sys)
	begin
		if (i_rst)
		begin
			o_cas_bit <= 1'b0;
			o_audio   <= '0;
		end
		else
		begin
			o_cas_bit <= tape_bit;
			o_audio   <= audio_next;
		end
	end

endmodule

`default_nettype wire

/* verilog/cas_cfg.svh */
`ifndef CAS_CFG_SVH
`define CAS_CFG_SVH

////////////////////////////////////////////////////////////////////////
// cassette input path sizing
////////////////////////////////////////////////////////////////////////

// audio ADC sample width in codes
`define CAS_ADC_W 12

// averaging depth as a power of two
// 9 gives a 512 sample window, roughly a 100 Hz high-pass at 48 kHz
`define CAS_AVG_LOG2 9

// hysteresis margin around the mean, in ADC codes
// about 0.1 V on the board ADC
`define CAS_THRESHOLD 100

////////////////////////////////////////////////////////////////////////
// audio side
////////////////////////////////////////////////////////////////////////

// sound DAC width from the machine core
`define CAS_SOUND_W 12

// mixed audio word sent to the codec
`define CAS_AUDIO_W 16

`endif

/* verilog/cas_input_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cas_cfg.svh"

// cassette input path
// capture -> dc tracker -> slicer -> source mux and audio mix
module cas_input_top
	import cas_pkg::*;
(
	input  wire logic                    clk_sys,
	input  wire logic                    i_rst,
	input  wire logic                    i_adc_sync,
	input  wire logic [`CAS_ADC_W-1:0]   i_adc_data,
	input  wire logic                    i_file_bit,
	input  wire logic                    i_src_adc,
	input  wire logic                    i_monitor,
	input  wire logic                    i_sndout,
	input  wire logic [`CAS_SOUND_W-1:0] i_sound,
	output logic                         o_sample_stb,
	output logic [`CAS_ADC_W-1:0]        o_sample,
	output logic [`CAS_ADC_W-1:0]        o_dc_level,
	output logic                         o_cas_bit,
	output logic [`CAS_AUDIO_W-1:0]      o_audio
);

	// capture to tracker
	logic        cap_stb;
	adc_sample_t cap_sample;

	// tracker to slicer, sample aligned with its mean
	logic        trk_stb;
	adc_sample_t trk_sample;
	adc_sample_t trk_level;

	// slicer result, held between strobes
	logic adc_bit;

	assign o_sample_stb = cap_stb;
	assign o_sample     = cap_sample;
	assign o_dc_level   = trk_level;

	adc_capture i_adc_capture (
		.clk_sys    (clk_sys),
		.i_rst      (i_rst),
		.i_adc_sync (i_adc_sync),
		.i_adc_data (i_adc_data),
		.o_stb      (cap_stb),
		.o_sample   (cap_sample)
	);

	dc_tracker #(
		.AVG_LOG2 (`CAS_AVG_LOG2)
	) i_dc_tracker (
		.clk_sys  (clk_sys),
		.i_rst    (i_rst),
		.i_stb    (cap_stb),
		.i_sample (cap_sample),
		.o_stb    (trk_stb),
		.o_sample (trk_sample),
		.o_level  (trk_level)
	);

	tape_slicer i_tape_slicer (
		.clk_sys   (clk_sys),
		.i_rst     (i_rst),
		.i_stb     (trk_stb),
		.i_sample  (trk_sample),
		.i_level   (trk_level),
		.o_adc_bit (adc_bit)
	);

	cas_audio_mixer i_cas_audio_mixer (
		.clk_sys    (clk_sys),
		.i_rst      (i_rst),
		.i_adc_bit  (adc_bit),
		.i_file_bit (i_file_bit),
		.i_src_adc  (i_src_adc),
		.i_monitor  (i_monitor),
		.i_sndout   (i_sndout),
		.i_sound    (i_sound),
		.o_cas_bit  (o_cas_bit),
		.o_audio    (o_audio)
	);

endmodule

`default_nettype wire

/* verilog/cas_pkg.sv */
`default_nettype none

`include "cas_cfg.svh"

package cas_pkg;

	// one ADC sample, also used for the mean level
	typedef logic [`CAS_ADC_W-1:0] adc_sample_t;

	// running sum over the full history window
	// one sample width plus the log2 of the depth, so it never overflows
	typedef logic [`CAS_ADC_W+`CAS_AVG_LOG2-1:0] adc_total_t;

	// sound DAC value from the machine
	typedef logic [`CAS_SOUND_W-1:0] sound_t;

	// mixed output word
	typedef logic [`CAS_AUDIO_W-1:0] audio_word_t;

	//////////////////////////////////////////////////////////////////////
	// derived sizes
	//////////////////////////////////////////////////////////////////////

	// number of zero bits padding the bottom of the audio word
	// speaker bit, sound bits, then the pad
	localparam int AUDIO_PAD_W = `CAS_AUDIO_W - `CAS_SOUND_W - 1;

endpackage

`default_nettype wire

/* verilog/dc_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cas_cfg.svh"

// running mean of the last 2**AVG_LOG2 ADC samples
// the mean acts as a high-pass reference for the slicer while the
// sample itself keeps its full high frequency content
module dc_tracker
	import cas_pkg::*;
#(
	parameter int AVG_LOG2 = `CAS_AVG_LOG2
)
(
	input  wire logic        clk_sys,
	input  wire logic        i_rst,
	input  wire logic        i_stb,
	input  wire adc_sample_t i_sample,
	output logic             o_stb,
	output adc_sample_t      o_sample,
	output adc_sample_t      o_level
);

	localparam int DEPTH   = 1 << AVG_LOG2;
	// sum of DEPTH samples needs AVG_LOG2 extra bits
	localparam int TOTAL_W = `CAS_ADC_W + AVG_LOG2;

	typedef logic [TOTAL_W-1:0]  total_t;
	typedef logic [AVG_LOG2-1:0] hist_ptr_t;
	typedef logic [AVG_LOG2:0]   hist_cnt_t;

	////////////////////////////////////////////////////////////////////
	// history window
	////////////////////////////////////////////////////////////////////

	// circular sample store
	adc_sample_t hist_mem [DEPTH];

	// next slot to write, which also holds the oldest sample once full
	hist_ptr_t wr_ptr;

	// samples written since reset, stops at DEPTH
	hist_cnt_t fill_cnt;
	logic      hist_full;

	// sample leaving the window on this strobe
	adc_sample_t oldest;

	// running total and its value after this strobe
	total_t total_q;
	total_t total_next;

	// top bit of the fill count is set exactly when DEPTH is reached
	assign hist_full = fill_cnt[AVG_LOG2];

	always_comb
	begin
		// empty slots count as zero until the window has filled once
		oldest     = hist_full ? hist_mem[wr_ptr] : '0;
		total_next = total_q + total_t'(i_sample) - total_t'(oldest);
	end

	// write port of the history
	always_ff @(posedge clk_sys)
	begin
		if (i_stb)
		begin
			hist_mem[wr_ptr] <= i_sample;
		end
	end

	////////////////////////////////////////////////////////////////////
	// pointer, fill count and total
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (i_rst)
		begin
			wr_ptr   <= '0;
			fill_cnt <= '0;
			total_q  <= '0;
		end
		else if (i_stb)
		begin
			// pointer wraps naturally at DEPTH
			wr_ptr  <= wr_ptr + 1'b1;
			total_q <= total_next;
			if (!hist_full)
			begin
				fill_cnt <= fill_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////////////

	// strobe and level carry reset, the sample is plain payload
	always_ff @(posedge clk_sys)
	begin
		if (i_rst)
		begin
			o_stb   <= 1'b0;
			o_level <= '0;
		end
		else
		begin
			o_stb <= i_stb;
			if (i_stb)
			begin
				// divide by DEPTH, mean of the updated window
				o_level <= total_next[TOTAL_W-1:AVG_LOG2];
			end
		end
	end

	// sample delayed to line up with its mean
	always_ff @(posedge clk_sys)
	begin
		if (i_stb)
		begin
			o_sample <= i_sample;
		end
	end

endmodule

`default_nettype wire

/* verilog/tape_slicer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cas_cfg.svh"

// hysteresis comparator recovering the tape bit
// polarity is inverted, a low swing gives a one as on the real machine
module tape_slicer
	import cas_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        i_rst,
	input  wire logic        i_stb,
	input  wire adc_sample_t i_sample,
	input  wire adc_sample_t i_level,
	output logic             o_adc_bit
);

	// one guard bit so sums near full scale do not wrap
	localparam int CMP_W = `CAS_ADC_W + 1;

	typedef logic [CMP_W-1:0] cmp_t;

	localparam cmp_t THRESHOLD = cmp_t'(`CAS_THRESHOLD);

	cmp_t sample_ext;
	cmp_t level_ext;
	logic below_band;
	logic above_band;

	////////////////////////////////////////////////////////////////////
	// band compare
	////////////////////////////////////////////////////////////////////

	always_comb
	begin
		sample_ext = cmp_t'(i_sample);
		level_ext  = cmp_t'(i_level);
		// sample more than the threshold under the mean
		below_band = (sample_ext + THRESHOLD) < level_ext;
		// sample more than the threshold over the mean
		above_band = sample_ext > (level_ext + THRESHOLD);
	end

	// inside the band the last decision is kept
	always_ff @(posedge clk_sys)
	begin
		if (i_rst)
		begin
			o_adc_bit <= 1'b0;
		end
		else if (i_stb)
		begin
			if (below_band)
			begin
				o_adc_bit <= 1'b1;
			end
			else if (above_band)
			begin
				o_adc_bit <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire
